// File: hw/hal_pkg.sv
package hal_pkg;

	//**********************************************************
	// Bus and register widths
	//**********************************************************

	// CPU strobe bus carries one byte per access
	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;

	// Implemented bits of each register, upper bits read zero
	localparam int MSTR_CTRL_W = 5;
	localparam int LED_W       = 4;
	localparam int RF_SEL_W    = 6;

	// One pending bit per event source
	localparam int EVENT_W     = 8;

	typedef logic [ADDR_W-1:0]  reg_addr_t;
	typedef logic [DATA_W-1:0]  reg_data_t;
	typedef logic [EVENT_W-1:0] event_t;
	typedef logic [LED_W-1:0]   led_t;

	//**********************************************************
	// Register map
	//**********************************************************

	// Default addresses, the top level may move them
	localparam reg_addr_t MSTR_CTRL_ADDR   = 8'h01;
	localparam reg_addr_t LED_ADDR         = 8'h02;
	localparam reg_addr_t RF_SELECT_ADDR   = 8'h03;
	localparam reg_addr_t EVT_PENDING_ADDR = 8'h04;
	localparam reg_addr_t EVT_MASK_ADDR    = 8'h05;

	//**********************************************************
	// Bit positions
	//**********************************************************

	// Master control, per-block resets and the RF clear request
	localparam int MSTR_RESET_RF0       = 0;
	localparam int MSTR_RESET_RF1       = 1;
	localparam int MSTR_RESET_CONTAINER = 2;
	localparam int MSTR_RESET_USB       = 3;
	localparam int MSTR_CLEAR_RF        = 4;

	// RF selection switches
	localparam int RFSEL_GPS_DC_BIAS = 0;
	localparam int RFSEL_GPS         = 1;
	localparam int RFSEL_ISM_EXT     = 2;
	localparam int RFSEL_ISM_TX      = 3;
	localparam int RFSEL_WB1_RX      = 4;
	localparam int RFSEL_WB2_RX      = 5;

endpackage

// File: hw/cpu_reg_bus.sv
`timescale 1ns/1ps

module cpu_reg_bus (
	input  logic                    clock_data,
	input  logic                    rst,

	// CPU strobe bus
	input  logic                    cpu_astrobe,
	input  logic                    cpu_wstrobe,
	input  logic                    cpu_rstrobe,
	inout  wire hal_pkg::reg_data_t cpu_dbus,

	// Read bytes returned by the register blocks
	input  hal_pkg::reg_data_t      rd_ctrl,
	input  hal_pkg::reg_data_t      rd_rf,
	input  hal_pkg::reg_data_t      rd_evt,

	// Register access toward the blocks
	output hal_pkg::reg_addr_t      reg_addr,
	output logic                    reg_wr,
	output hal_pkg::reg_data_t      reg_wdata
);
	import hal_pkg::*;

	logic      addr_cycle;
	reg_data_t rd_merge;

	//**********************************************************
	// Strobe decode
	//**********************************************************

	// Address phase, both strobes high together
	assign addr_cycle = cpu_astrobe & cpu_wstrobe;

	// Data write, write strobe alone
	// Comes straight from the strobe so the target latches on this edge
	assign reg_wr = cpu_wstrobe & ~cpu_astrobe;

	// Write byte is whatever the CPU has on the bus
	assign reg_wdata = cpu_dbus;

	//**********************************************************
	// Address latch
	//**********************************************************

	// Held across any number of data accesses
	always_ff @(posedge clock_data) begin
		if (rst) begin
			reg_addr <= '0;
		end else if (addr_cycle) begin
			reg_addr <= cpu_dbus;
		end
	end

	//**********************************************************
	// Read return
	//**********************************************************

	// Blocks return zero when not addressed, so an OR merges them
	assign rd_merge = rd_ctrl | rd_rf | rd_evt;

	// Drive only while the CPU reads
	// Released to high impedance at all other times
	assign cpu_dbus = cpu_rstrobe ? rd_merge : 'z;

endmodule

// File: hw/hal_ctrl_regs.sv
`timescale 1ns/1ps

module hal_ctrl_regs #(
	parameter hal_pkg::reg_addr_t MSTR_ADDR    = hal_pkg::MSTR_CTRL_ADDR,
	parameter hal_pkg::reg_addr_t LED_REG_ADDR = hal_pkg::LED_ADDR
) (
	input  logic               clock_data,
	input  logic               rst,

	// Register access
	input  hal_pkg::reg_addr_t reg_addr,
	input  logic               reg_wr,
	input  hal_pkg::reg_data_t reg_wdata,
	output hal_pkg::reg_data_t rd_ctrl,

	// General-purpose LEDs
	output hal_pkg::led_t      led,

	// Reset outputs for the blocks outside this core
	output logic               rf0_reset,
	output logic               rf1_reset,
	output logic               container_reset,
	output logic               usb_reset,

	// One-cycle RF clear
	output logic               aclr_rf
);
	import hal_pkg::*;

	logic [MSTR_CTRL_W-1:0] mstr_ctrl;
	logic                   mstr_wr;
	logic                   led_wr;
	logic                   clear_dly;

	//**********************************************************
	// Write decode
	//**********************************************************

	assign mstr_wr = reg_wr && (reg_addr == MSTR_ADDR);
	assign led_wr  = reg_wr && (reg_addr == LED_REG_ADDR);

	// Master control
	//   bits 3:0 hold the per-block resets
	//   bit 4 requests a clear of both RF channels
	always_ff @(posedge clock_data) begin
		if (rst) begin
			mstr_ctrl <= '0;
		end else if (mstr_wr) begin
			mstr_ctrl <= reg_wdata[MSTR_CTRL_W-1:0];
		end
	end

	// LED register drives the pins directly
	always_ff @(posedge clock_data) begin
		if (rst) begin
			led <= '0;
		end else if (led_wr) begin
			led <= reg_wdata[LED_W-1:0];
		end
	end

	//**********************************************************
	// Readback
	//**********************************************************

	// Zero when neither address matches
	always_comb begin
		rd_ctrl = '0;
		if (reg_addr == MSTR_ADDR) begin
			rd_ctrl = reg_data_t'(mstr_ctrl);
		end else if (reg_addr == LED_REG_ADDR) begin
			rd_ctrl = reg_data_t'(led);
		end
	end

	//**********************************************************
	// Block resets and clear pulse
	//**********************************************************

	// System reset always reaches every block
	assign rf0_reset       = rst | mstr_ctrl[MSTR_RESET_RF0];
	assign rf1_reset       = rst | mstr_ctrl[MSTR_RESET_RF1];
	assign container_reset = rst | mstr_ctrl[MSTR_RESET_CONTAINER];
	assign usb_reset       = rst | mstr_ctrl[MSTR_RESET_USB];

	// Previous value of the clear bit
	always_ff @(posedge clock_data) begin
		if (rst) begin
			clear_dly <= 1'b0;
		end else begin
			clear_dly <= mstr_ctrl[MSTR_CLEAR_RF];
		end
	end

	// Rising edge only, a rewrite of 1 leaves the bit and its copy equal
	assign aclr_rf = mstr_ctrl[MSTR_CLEAR_RF] & ~clear_dly;

endmodule

// File: hw/rf_switch_ctrl.sv
`timescale 1ns/1ps

module rf_switch_ctrl #(
	parameter hal_pkg::reg_addr_t RF_SEL_ADDR = hal_pkg::RF_SELECT_ADDR
) (
	input  logic               clock_data,
	input  logic               rst,

	// Register access
	input  hal_pkg::reg_addr_t reg_addr,
	input  logic               reg_wr,
	input  hal_pkg::reg_data_t reg_wdata,
	output hal_pkg::reg_data_t rd_rf,

	// SPDT switch pin pairs
	output logic               rf_wb1_rx_select,
	output logic               rf_wb1_n_rx_select,
	output logic               rf_wb2_rx_select,
	output logic               rf_wb2_n_rx_select,
	output logic               rf_ism_tx_select,
	output logic               rf_ism_n_tx_select,
	output logic               rf_ism_ext_select,
	output logic               rf_ism_n_ext_select,
	output logic               rf_gps_ext_select,
	output logic               rf_gps_n_ext_select,
	output logic               rf_gps_dc_bias_select
);
	import hal_pkg::*;

	logic [RF_SEL_W-1:0] rf_sel;

	//**********************************************************
	// Selection register
	//**********************************************************

	always_ff @(posedge clock_data) begin
		if (rst) begin
			rf_sel <= '0;
		end else if (reg_wr && (reg_addr == RF_SEL_ADDR)) begin
			rf_sel <= reg_wdata[RF_SEL_W-1:0];
		end
	end

	// Upper bits read as zero
	assign rd_rf = (reg_addr == RF_SEL_ADDR) ? reg_data_t'(rf_sel) : '0;

	//**********************************************************
	// Switch pin drive
	//**********************************************************

	// Wideband receive switches follow the register bit
	assign rf_wb1_rx_select   =  rf_sel[RFSEL_WB1_RX];
	assign rf_wb1_n_rx_select = ~rf_sel[RFSEL_WB1_RX];
	assign rf_wb2_rx_select   =  rf_sel[RFSEL_WB2_RX];
	assign rf_wb2_n_rx_select = ~rf_sel[RFSEL_WB2_RX];

	// ISM pairs are swapped on the schematic
	// so the affirmative pin carries the inverted bit
	assign rf_ism_tx_select    = ~rf_sel[RFSEL_ISM_TX];
	assign rf_ism_n_tx_select  =  rf_sel[RFSEL_ISM_TX];
	assign rf_ism_ext_select   = ~rf_sel[RFSEL_ISM_EXT];
	assign rf_ism_n_ext_select =  rf_sel[RFSEL_ISM_EXT];

	// Same swap for GPS, a zero register selects the internal antenna
	assign rf_gps_ext_select   = ~rf_sel[RFSEL_GPS];
	assign rf_gps_n_ext_select =  rf_sel[RFSEL_GPS];

	// Single-ended bias enable
	assign rf_gps_dc_bias_select = rf_sel[RFSEL_GPS_DC_BIAS];

endmodule

// File: hw/event_interrupt.sv
`timescale 1ns/1ps

module event_interrupt #(
	parameter hal_pkg::reg_addr_t PENDING_ADDR = hal_pkg::EVT_PENDING_ADDR,
	parameter hal_pkg::reg_addr_t MASK_ADDR    = hal_pkg::EVT_MASK_ADDR
) (
	input  logic               clock_data,
	input  logic               rst,

	// Register access
	input  hal_pkg::reg_addr_t reg_addr,
	input  logic               reg_wr,
	input  hal_pkg::reg_data_t reg_wdata,
	output hal_pkg::reg_data_t rd_evt,

	// Event pulses from the sources
	input  hal_pkg::event_t    evtsig,

	// Level interrupt toward the CPU
	output logic               cpu_interrupt
);
	import hal_pkg::*;

	event_t pending;
	event_t mask;
	event_t clr_bits;

	//**********************************************************
	// Pending register
	//**********************************************************

	// Bits written as 1 to the pending address are cleared
	assign clr_bits = (reg_wr && (reg_addr == PENDING_ADDR)) ? event_t'(reg_wdata) : '0;

	// Sticky capture
	// An event in the same cycle as its clear stays pending
	always_ff @(posedge clock_data) begin
		if (rst) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clr_bits) | evtsig;
		end
	end

	//**********************************************************
	// Mask register
	//**********************************************************

	// 1 lets the event reach the interrupt line
	always_ff @(posedge clock_data) begin
		if (rst) begin
			mask <= '0;
		end else if (reg_wr && (reg_addr == MASK_ADDR)) begin
			mask <= event_t'(reg_wdata);
		end
	end

	//**********************************************************
	// Readback and interrupt
	//**********************************************************

	always_comb begin
		rd_evt = '0;
		if (reg_addr == PENDING_ADDR) begin
			rd_evt = reg_data_t'(pending);
		end else if (reg_addr == MASK_ADDR) begin
			rd_evt = reg_data_t'(mask);
		end
	end

	// Any unmasked pending event
	assign cpu_interrupt = |(pending & mask);

endmodule

// File: hw/wca_hal_top.sv
`timescale 1ns/1ps

module wca_hal_top #(
	parameter hal_pkg::reg_addr_t MSTR_ADDR    = hal_pkg::MSTR_CTRL_ADDR,
	parameter hal_pkg::reg_addr_t LED_REG_ADDR = hal_pkg::LED_ADDR,
	parameter hal_pkg::reg_addr_t RF_SEL_ADDR  = hal_pkg::RF_SELECT_ADDR,
	parameter hal_pkg::reg_addr_t PENDING_ADDR = hal_pkg::EVT_PENDING_ADDR,
	parameter hal_pkg::reg_addr_t MASK_ADDR    = hal_pkg::EVT_MASK_ADDR
) (
	input  logic                    clock_data,
	input  logic                    rst,

	// CPU strobe bus and interrupt
	input  logic                    cpu_astrobe,
	input  logic                    cpu_wstrobe,
	input  logic                    cpu_rstrobe,
	inout  wire hal_pkg::reg_data_t cpu_dbus,
	output logic                    cpu_interrupt,

	// Event sources
	input  hal_pkg::event_t         evtsig,

	// LEDs
	output hal_pkg::led_t           led,

	// RF selection switches
	output logic                    rf_wb1_rx_select,
	output logic                    rf_wb1_n_rx_select,
	output logic                    rf_wb2_rx_select,
	output logic                    rf_wb2_n_rx_select,
	output logic                    rf_ism_tx_select,
	output logic                    rf_ism_n_tx_select,
	output logic                    rf_ism_ext_select,
	output logic                    rf_ism_n_ext_select,
	output logic                    rf_gps_ext_select,
	output logic                    rf_gps_n_ext_select,
	output logic                    rf_gps_dc_bias_select,

	// Resets and clear for the external blocks
	output logic                    rf0_reset,
	output logic                    rf1_reset,
	output logic                    container_reset,
	output logic                    usb_reset,
	output logic                    aclr_rf
);
	import hal_pkg::*;

	// Register bus fan-out
	reg_addr_t reg_addr;
	logic      reg_wr;
	reg_data_t reg_wdata;

	// Read bytes back from each block
	reg_data_t rd_ctrl;
	reg_data_t rd_rf;
	reg_data_t rd_evt;

	//**********************************************************
	// CPU bus
	//**********************************************************

	cpu_reg_bus i_cpu_reg_bus (
		.clock_data  (clock_data),
		.rst         (rst),
		.cpu_astrobe (cpu_astrobe),
		.cpu_wstrobe (cpu_wstrobe),
		.cpu_rstrobe (cpu_rstrobe),
		.cpu_dbus    (cpu_dbus),
		.rd_ctrl     (rd_ctrl),
		.rd_rf       (rd_rf),
		.rd_evt      (rd_evt),
		.reg_addr    (reg_addr),
		.reg_wr      (reg_wr),
		.reg_wdata   (reg_wdata)
	);

	//**********************************************************
	// Register blocks
	//**********************************************************

	// Master control and LEDs
	hal_ctrl_regs #(
		.MSTR_ADDR    (MSTR_ADDR),
		.LED_REG_ADDR (LED_REG_ADDR)
	) i_hal_ctrl_regs (
		.clock_data      (clock_data),
		.rst             (rst),
		.reg_addr        (reg_addr),
		.reg_wr          (reg_wr),
		.reg_wdata       (reg_wdata),
		.rd_ctrl         (rd_ctrl),
		.led             (led),
		.rf0_reset       (rf0_reset),
		.rf1_reset       (rf1_reset),
		.container_reset (container_reset),
		.usb_reset       (usb_reset),
		.aclr_rf         (aclr_rf)
	);

	// Antenna path selection
	rf_switch_ctrl #(
		.RF_SEL_ADDR (RF_SEL_ADDR)
	) i_rf_switch_ctrl (
		.clock_data            (clock_data),
		.rst                   (rst),
		.reg_addr              (reg_addr),
		.reg_wr                (reg_wr),
		.reg_wdata             (reg_wdata),
		.rd_rf                 (rd_rf),
		.rf_wb1_rx_select      (rf_wb1_rx_select),
		.rf_wb1_n_rx_select    (rf_wb1_n_rx_select),
		.rf_wb2_rx_select      (rf_wb2_rx_select),
		.rf_wb2_n_rx_select    (rf_wb2_n_rx_select),
		.rf_ism_tx_select      (rf_ism_tx_select),
		.rf_ism_n_tx_select    (rf_ism_n_tx_select),
		.rf_ism_ext_select     (rf_ism_ext_select),
		.rf_ism_n_ext_select   (rf_ism_n_ext_select),
		.rf_gps_ext_select     (rf_gps_ext_select),
		.rf_gps_n_ext_select   (rf_gps_n_ext_select),
		.rf_gps_dc_bias_select (rf_gps_dc_bias_select)
	);

	// Event capture and CPU interrupt
	event_interrupt #(
		.PENDING_ADDR (PENDING_ADDR),
		.MASK_ADDR    (MASK_ADDR)
	) i_event_interrupt (
		.clock_data    (clock_data),
		.rst           (rst),
		.reg_addr      (reg_addr),
		.reg_wr        (reg_wr),
		.reg_wdata     (reg_wdata),
		.evtsig        (evtsig),
		.rd_evt        (rd_evt),
		.cpu_interrupt (cpu_interrupt)
	);

endmodule

// File: bench/tb_wca_hal.sv
`timescale 1ns/1ps

module tb_wca_hal;
	import hal_pkg::*;

	// Iterations per random test
	localparam int N_RB  = 48;
	localparam int N_OUT = 24;
	localparam int N_RF  = 24;
	localparam int N_EVT = 32;

	// Upper bound of bus cycles per test, summed for the watchdog
	localparam int TOTAL_CYCLES = 40 + N_RB * 6 + N_OUT * 8 + N_RF * 4 + 40 + N_EVT * 20 + 40;
	localparam int MARGIN_CYCLES = 500;

	logic      clock_data = 1'b0;
	logic      rst;
	logic      cpu_astrobe;
	logic      cpu_wstrobe;
	logic      cpu_rstrobe;
	wire       reg_data_t cpu_dbus;
	logic      cpu_interrupt;
	event_t    evtsig;
	led_t      led;
	logic      rf_wb1_rx_select;
	logic      rf_wb1_n_rx_select;
	logic      rf_wb2_rx_select;
	logic      rf_wb2_n_rx_select;
	logic      rf_ism_tx_select;
	logic      rf_ism_n_tx_select;
	logic      rf_ism_ext_select;
	logic      rf_ism_n_ext_select;
	logic      rf_gps_ext_select;
	logic      rf_gps_n_ext_select;
	logic      rf_gps_dc_bias_select;
	logic      rf0_reset;
	logic      rf1_reset;
	logic      container_reset;
	logic      usb_reset;
	logic      aclr_rf;

	// Testbench side of the shared data bus
	reg_data_t dbus_out;
	logic      dbus_oe;

	// Shadow copies of the DUT registers
	logic [4:0] m_mstr;
	led_t       m_led;
	logic [5:0] m_rf;
	event_t     m_pend;
	event_t     m_mask;

	integer seed = 32'h7bf8cd32;
	int     errors;
	int     checks;
	int     tests;
	int     test_err;
	string  test_name;

	assign cpu_dbus = dbus_oe ? dbus_out : 'z;

	always #5 clock_data = ~clock_data;

	wca_hal_top i_dut (.*);

	//**********************************************************
	// Compare tasks
	//**********************************************************

	task automatic check_data(input string what, input reg_data_t exp, input reg_data_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_led(input string what, input led_t exp, input led_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %b actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_event(input string what, input event_t exp, input event_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err  = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-12s done, %0d errors", test_name, errors - test_err);
	endtask

	//**********************************************************
	// Bus cycles
	//**********************************************************

	// Both strobes high, byte is the address
	task automatic bus_addr(input reg_addr_t a);
		@(posedge clock_data);
		cpu_astrobe <= 1'b1;
		cpu_wstrobe <= 1'b1;
		cpu_rstrobe <= 1'b0;
		dbus_out    <= a;
		dbus_oe     <= 1'b1;
	endtask

	task automatic bus_idle();
		@(posedge clock_data);
		cpu_astrobe <= 1'b0;
		cpu_wstrobe <= 1'b0;
		cpu_rstrobe <= 1'b0;
		dbus_oe     <= 1'b0;
	endtask

	// Returns right after the write edge
	task automatic bus_write(input reg_data_t d);
		@(posedge clock_data);
		cpu_astrobe <= 1'b0;
		cpu_wstrobe <= 1'b1;
		cpu_rstrobe <= 1'b0;
		dbus_out    <= d;
		dbus_oe     <= 1'b1;
		bus_idle();
	endtask

	// DUT drives the bus, sampled mid-cycle
	task automatic bus_read(output reg_data_t d);
		@(posedge clock_data);
		cpu_astrobe <= 1'b0;
		cpu_wstrobe <= 1'b0;
		cpu_rstrobe <= 1'b1;
		dbus_oe     <= 1'b0;
		@(negedge clock_data);
		d = cpu_dbus;
		bus_idle();
	endtask

	//**********************************************************
	// Reference model
	//**********************************************************

	function automatic reg_data_t model_read(input reg_addr_t a);
		case (a)
			MSTR_CTRL_ADDR:   return {3'b000, m_mstr};
			LED_ADDR:         return {4'b0000, m_led};
			RF_SELECT_ADDR:   return {2'b00, m_rf};
			EVT_PENDING_ADDR: return m_pend;
			EVT_MASK_ADDR:    return m_mask;
			default:          return 8'h00;
		endcase
	endfunction

	// Pending is write one to clear, unmapped writes vanish
	task automatic model_write(input reg_addr_t a, input reg_data_t d);
		case (a)
			MSTR_CTRL_ADDR:   m_mstr = d[4:0];
			LED_ADDR:         m_led = d[3:0];
			RF_SELECT_ADDR:   m_rf = d[5:0];
			EVT_PENDING_ADDR: m_pend = m_pend & ~d;
			EVT_MASK_ADDR:    m_mask = d;
			default:          ;
		endcase
	endtask

	task automatic write_reg(input reg_addr_t a, input reg_data_t d);
		bus_addr(a);
		bus_write(d);
		model_write(a, d);
	endtask

	task automatic read_check(input reg_addr_t a);
		reg_data_t v;
		bus_addr(a);
		bus_read(v);
		check_data($sformatf("read of %h", a), model_read(a), v);
	endtask

	task automatic read_event(input reg_addr_t a, input string what);
		reg_data_t v;
		bus_addr(a);
		bus_read(v);
		check_event(what, event_t'(model_read(a)), event_t'(v));
	endtask

	// Pin levels from the polarity rules, ISM and GPS swapped
	task automatic check_rf_pins();
		check_bit("wb1 rx", m_rf[4], rf_wb1_rx_select);
		check_bit("wb1 n rx", ~m_rf[4], rf_wb1_n_rx_select);
		check_bit("wb2 rx", m_rf[5], rf_wb2_rx_select);
		check_bit("wb2 n rx", ~m_rf[5], rf_wb2_n_rx_select);
		check_bit("ism tx", ~m_rf[3], rf_ism_tx_select);
		check_bit("ism n tx", m_rf[3], rf_ism_n_tx_select);
		check_bit("ism ext", ~m_rf[2], rf_ism_ext_select);
		check_bit("ism n ext", m_rf[2], rf_ism_n_ext_select);
		check_bit("gps ext", ~m_rf[1], rf_gps_ext_select);
		check_bit("gps n ext", m_rf[1], rf_gps_n_ext_select);
		check_bit("gps dc bias", m_rf[0], rf_gps_dc_bias_select);
		// Every pair must be complementary
		check_bit("wb1 pair", 1'b1, rf_wb1_rx_select ^ rf_wb1_n_rx_select);
		check_bit("wb2 pair", 1'b1, rf_wb2_rx_select ^ rf_wb2_n_rx_select);
		check_bit("ism tx pair", 1'b1, rf_ism_tx_select ^ rf_ism_n_tx_select);
		check_bit("ism ext pair", 1'b1, rf_ism_ext_select ^ rf_ism_n_ext_select);
		check_bit("gps pair", 1'b1, rf_gps_ext_select ^ rf_gps_n_ext_select);
	endtask

	task automatic check_resets();
		check_bit("rf0_reset", m_mstr[0], rf0_reset);
		check_bit("rf1_reset", m_mstr[1], rf1_reset);
		check_bit("container_reset", m_mstr[2], container_reset);
		check_bit("usb_reset", m_mstr[3], usb_reset);
	endtask

	// Pulse lands one cycle after the write edge, gone the cycle after
	task automatic clear_step(input reg_data_t d, input logic pulse);
		write_reg(MSTR_CTRL_ADDR, d);
		@(negedge clock_data);
		check_bit($sformatf("aclr_rf after %h", d), pulse, aclr_rf);
		@(negedge clock_data);
		check_bit($sformatf("aclr_rf second cycle %h", d), 1'b0, aclr_rf);
	endtask

	task automatic pulse_event(input event_t e);
		@(posedge clock_data);
		evtsig <= e;
		@(posedge clock_data);
		evtsig <= '0;
		m_pend = m_pend | e;
		@(negedge clock_data);
	endtask

	// Clear write and event pulse share one edge
	task automatic clear_with_event(input reg_data_t d, input event_t e);
		bus_addr(EVT_PENDING_ADDR);
		@(posedge clock_data);
		cpu_astrobe <= 1'b0;
		cpu_wstrobe <= 1'b1;
		dbus_out    <= d;
		dbus_oe     <= 1'b1;
		evtsig      <= e;
		@(posedge clock_data);
		cpu_wstrobe <= 1'b0;
		dbus_oe     <= 1'b0;
		evtsig      <= '0;
		m_pend = (m_pend & ~d) | e;
	endtask

	//**********************************************************
	// Test sequence
	//**********************************************************

	initial begin
		reg_data_t d;
		reg_addr_t a;
		event_t    e;
		logic      old_clr;
		integer    r;

		rst         = 1'b1;
		cpu_astrobe = 1'b0;
		cpu_wstrobe = 1'b0;
		cpu_rstrobe = 1'b0;
		evtsig      = '0;
		dbus_out    = '0;
		dbus_oe     = 1'b0;
		m_mstr      = '0;
		m_led       = '0;
		m_rf        = '0;
		m_pend      = '0;
		m_mask      = '0;
		errors      = 0;
		checks      = 0;
		tests       = 0;

		// Reset state
		begin_test("reset");
		repeat (2) @(posedge clock_data);
		@(negedge clock_data);
		check_bit("rf0_reset in rst", 1'b1, rf0_reset);
		check_bit("rf1_reset in rst", 1'b1, rf1_reset);
		check_bit("container_reset in rst", 1'b1, container_reset);
		check_bit("usb_reset in rst", 1'b1, usb_reset);
		@(posedge clock_data);
		rst <= 1'b0;
		@(negedge clock_data);
		check_resets();
		check_bit("cpu_interrupt", 1'b0, cpu_interrupt);
		check_bit("aclr_rf", 1'b0, aclr_rf);
		check_led("led", '0, led);
		check_rf_pins();
		check_bit("bus released", 1'b1, cpu_dbus === 8'hzz);
		for (int i = 0; i < 8; i++) begin
			read_check(reg_addr_t'(i));
		end
		end_test();

		// Readback, mostly near the map, sometimes anywhere
		begin_test("readback");
		for (int i = 0; i < N_RB; i++) begin
			r = $random(seed);
			a = r[8] ? reg_addr_t'(r[7:0]) : reg_addr_t'(r[2:0]);
			d = $random(seed);
			write_reg(a, d);
			read_check(a);
		end
		end_test();

		begin_test("outputs");
		for (int i = 0; i < N_OUT; i++) begin
			d = $random(seed);
			old_clr = m_mstr[4];
			write_reg(MSTR_CTRL_ADDR, d);
			@(negedge clock_data);
			check_resets();
			check_bit("aclr_rf edge", m_mstr[4] & ~old_clr, aclr_rf);
			d = $random(seed);
			write_reg(LED_ADDR, d);
			@(negedge clock_data);
			check_led("led", m_led, led);
		end
		end_test();

		begin_test("rf_switch");
		for (int i = 0; i < N_RF; i++) begin
			d = $random(seed);
			write_reg(RF_SELECT_ADDR, d);
			@(negedge clock_data);
			check_rf_pins();
		end
		end_test();

		begin_test("clear_pulse");
		write_reg(MSTR_CTRL_ADDR, 8'h00);
		clear_step(8'h10, 1'b1);
		clear_step(8'h10, 1'b0);
		clear_step(8'h1f, 1'b0);
		clear_step(8'h0f, 1'b0);
		clear_step(8'h1f, 1'b1);
		write_reg(MSTR_CTRL_ADDR, 8'h00);
		end_test();

		begin_test("interrupt");
		write_reg(EVT_PENDING_ADDR, 8'hff);
		for (int i = 0; i < N_EVT; i++) begin
			if (i % 4 == 0) begin
				d = $random(seed);
				write_reg(EVT_MASK_ADDR, d);
				read_event(EVT_MASK_ADDR, "mask");
			end
			// Sparse pulses, two random words ANDed
			e = $random(seed) & $random(seed);
			pulse_event(e);
			check_bit("cpu_interrupt", |(m_pend & m_mask), cpu_interrupt);
			read_event(EVT_PENDING_ADDR, "pending");
			if (i % 3 == 2) begin
				d = $random(seed);
				write_reg(EVT_PENDING_ADDR, d);
				@(negedge clock_data);
				check_bit("cpu_interrupt after clear", |(m_pend & m_mask), cpu_interrupt);
				read_event(EVT_PENDING_ADDR, "pending after clear");
			end
		end
		for (int i = 0; i < 4; i++) begin
			e = $random(seed);
			clear_with_event(8'hff, e);
			@(negedge clock_data);
			check_bit("cpu_interrupt event vs clear", |(m_pend & m_mask), cpu_interrupt);
			read_event(EVT_PENDING_ADDR, "event wins over clear");
		end
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((TOTAL_CYCLES + MARGIN_CYCLES) * 10);
		$display("Watchdog expired, the test sequence hung and did not finish");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: sim.f
hw/hal_pkg.sv
hw/cpu_reg_bus.sv
hw/hal_ctrl_regs.sv
hw/rf_switch_ctrl.sv
hw/event_interrupt.sv
hw/wca_hal_top.sv
bench/tb_wca_hal.sv
